//--- hdl/videoPkg.sv
`default_nettype none

package videoPkg;

	// raster size, one pixel per clock
	localparam int screenWidth = 64;
	localparam int screenHeight = 32;
	localparam int coordWidth = 7; // wide enough for both counters

	// life icons sit in a row near the top right
	localparam int numIcons = 3;
	localparam int iconSize = 8; // square icon, pixels per side
	localparam int iconTopY = 2; // shared top row
	localparam int iconLeftX0 = 30; // icon 0, leftmost
	localparam int iconLeftX1 = 40;
	localparam int iconLeftX2 = 50; // icon 2, first to go

	// 8-bit packed color word
	typedef logic [7:0] color_t;

	localparam color_t iconColor = 8'h5B; // life icon fill
	localparam color_t transparentColor = 8'hFF; // reserved, never shown
	localparam color_t backgroundColor = 8'h00; // normal play
	localparam color_t gameOverColor = 8'hE0; // red screen once lives are gone

endpackage

`default_nettype wire

//--- hdl/gamePkg.sv
`default_nettype none

package gamePkg;

	// game flow states
	typedef enum logic [1:0] {
		stIdle, // attract mode, only a restart leaves it
		stPlay,
		stOver
	} gameState_t;

	// event opcodes, strobed with eventValid
	typedef enum logic [1:0] {
		evNone,
		evDie,
		evPrize,
		evRestart
	} eventCode_t;

	typedef logic [1:0] lives_t; // life count, 0 to maxLives

	localparam lives_t maxLives = 2'd3; // also the count after restart

endpackage

`default_nettype wire

//--- hdl/pixelIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pixelIf ();
	import videoPkg::*;

	logic [coordWidth-1:0] pixelX; // current column
	logic [coordWidth-1:0] pixelY; // current row
	logic active; // scanner is running
	logic frameStart; // pixel (0,0) cycle

	// scanner side
	modport source (output pixelX, pixelY, active, frameStart);

	// consumers of the raster position
	modport sink (input pixelX, pixelY, active, frameStart);

endinterface

`default_nettype wire

//--- hdl/pixelScanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixelScanner (
	input logic clk,
	input logic resetN,
	pixelIf.source pix
);
	import videoPkg::*;

	localparam logic [coordWidth-1:0] lastX = coordWidth'(screenWidth - 1); // last column
	localparam logic [coordWidth-1:0] lastY = coordWidth'(screenHeight - 1); // last row

	logic [coordWidth-1:0] colCnt; // column counter
	logic [coordWidth-1:0] rowCnt; // row counter
	logic running; // set on the first clock out of reset

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			colCnt <= '0; // park at (0,0) so frameStart shows up at once
			rowCnt <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (colCnt == lastX) begin // end of line
				colCnt <= '0;
				if (rowCnt == lastY) begin // end of frame
					rowCnt <= '0;
				end else begin
					rowCnt <= rowCnt + 1'b1;
				end
			end else begin
				colCnt <= colCnt + 1'b1;
			end
		end
	end

	assign pix.pixelX = colCnt;
	assign pix.pixelY = rowCnt;
	assign pix.active = running;
	assign pix.frameStart = (colCnt == '0) && (rowCnt == '0); // one cycle per frame

endmodule

`default_nettype wire

//--- hdl/gameControl.sv
`timescale 1ns/1ps
`default_nettype none

module gameControl (
	input logic clk,
	input logic resetN,
	input logic eventValid,
	input gamePkg::eventCode_t eventCode,
	output gamePkg::lives_t lives,
	output logic gameOver
);
	import gamePkg::*;

	gameState_t state; // current game state
	gameState_t stateNext;
	lives_t livesNext;

	// next state and next life count from the event strobe
	always_comb begin
		stateNext = state;
		livesNext = lives;
		if (eventValid) begin
			if (eventCode == evRestart) begin // restart wins from any state
				stateNext = stPlay;
				livesNext = maxLives;
			end else begin
				case (state)
					stPlay: begin
						if (eventCode == evDie) begin
							if (lives <= lives_t'(1)) begin // last life lost
								livesNext = '0;
								stateNext = stOver;
							end else begin
								livesNext = lives - 1'b1;
							end
						end else if (eventCode == evPrize && lives < maxLives) begin
							livesNext = lives + 1'b1; // saturates at maxLives
						end
					end
					stOver, stIdle: begin
						// die and prize are dropped here, only a restart leaves
					end
					default: begin
						stateNext = stPlay;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= stPlay; // game starts running with full lives
			lives <= maxLives;
			gameOver <= 1'b0;
		end else begin
			state <= stateNext;
			lives <= livesNext; // one cycle from strobe to new count
			gameOver <= (stateNext == stOver); // registered decode of stOver
		end
	end

endmodule

`default_nettype wire

//--- hdl/lifeIconDrawer.sv
`timescale 1ns/1ps
`default_nettype none

module lifeIconDrawer (
	input logic clk,
	input logic resetN,
	pixelIf.sink pix,
	input gamePkg::lives_t lives,
	output logic drawRequest,
	output logic [videoPkg::coordWidth-1:0] offsetX,
	output logic [videoPkg::coordWidth-1:0] offsetY
);
	import videoPkg::*;
	import gamePkg::*;

	// left columns indexed by icon number
	localparam int iconLeftX [numIcons] = '{iconLeftX0, iconLeftX1, iconLeftX2};

	lives_t livesSnap; // lives as seen by the whole current frame
	logic inRows; // pixel lies in the icon row band
	logic hit; // pixel inside an enabled bracket
	logic [coordWidth-1:0] hitX; // offset from bracket top left
	logic [coordWidth-1:0] hitY;

	// snapshot once per frame so icons never tear mid-frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			livesSnap <= maxLives;
		end else if (pix.frameStart) begin
			livesSnap <= lives;
		end
	end

	always_comb begin
		hit = 1'b0;
		hitX = '0;
		hitY = '0;
		inRows = (int'(pix.pixelY) >= iconTopY) &&
			(int'(pix.pixelY) < iconTopY + iconSize); // same rows for all icons
		// walk right to left, so the leftmost enabled bracket is applied last
		for (int k = numIcons - 1; k >= 0; k--) begin
			if (pix.active && inRows && (int'(livesSnap) > k) &&
					(int'(pix.pixelX) >= iconLeftX[k]) &&
					(int'(pix.pixelX) < iconLeftX[k] + iconSize)) begin
				hit = 1'b1;
				hitX = pix.pixelX - coordWidth'(iconLeftX[k]);
				hitY = pix.pixelY - coordWidth'(iconTopY);
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawRequest <= 1'b0;
		end else begin
			drawRequest <= hit; // first pipeline stage
		end
	end

	// offsets go to zero outside the brackets
	always_ff @(posedge clk) begin
		offsetX <= hitX;
		offsetY <= hitY;
	end

endmodule

`default_nettype wire

//--- hdl/iconBitmap.sv
`timescale 1ns/1ps
`default_nettype none

module iconBitmap (
	input logic clk,
	input logic resetN,
	input logic drawRequest,
	input logic [videoPkg::coordWidth-1:0] offsetX,
	input logic [videoPkg::coordWidth-1:0] offsetY,
	output videoPkg::color_t iconRgb,
	output logic iconRequest
);
	import videoPkg::*;

	localparam logic [coordWidth-1:0] lastOffset = coordWidth'(iconSize - 1);

	logic edgeX; // on left or right column of the icon
	logic edgeY; // on top or bottom row
	logic opaque; // requested pixel that is not a corner

	// filled square with the four corners knocked out
	assign edgeX = (offsetX == '0) || (offsetX == lastOffset);
	assign edgeY = (offsetY == '0) || (offsetY == lastOffset);
	assign opaque = drawRequest && !(edgeX && edgeY);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			iconRequest <= 1'b0;
		end else begin
			iconRequest <= opaque; // second pipeline stage
		end
	end

	always_ff @(posedge clk) begin
		iconRgb <= opaque ? iconColor : transparentColor;
	end

endmodule

`default_nettype wire

//--- hdl/layerMux.sv
`timescale 1ns/1ps
`default_nettype none

module layerMux (
	input logic clk,
	input logic resetN,
	input videoPkg::color_t iconRgb,
	input logic iconRequest,
	input logic gameOver,
	output videoPkg::color_t rgb
);
	import videoPkg::*;

	color_t backColor; // background layer color

	assign backColor = gameOver ? gameOverColor : backgroundColor; // slow state, no resync

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rgb <= backgroundColor;
		end else if (iconRequest) begin
			rgb <= iconRgb; // icon layer on top
		end else begin
			rgb <= backColor; // third pipeline stage
		end
	end

endmodule

`default_nettype wire

//--- hdl/hudTop.sv
`timescale 1ns/1ps
`default_nettype none

module hudTop (
	input logic clk,
	input logic resetN,
	input logic eventValid,
	input gamePkg::eventCode_t eventCode,
	output logic [videoPkg::coordWidth-1:0] pixelX,
	output logic [videoPkg::coordWidth-1:0] pixelY,
	output logic frameStart,
	output gamePkg::lives_t lives,
	output logic gameOver,
	output videoPkg::color_t rgb
);
	import videoPkg::*;

	pixelIf pixBus (); // raster position bus

	logic drawRequest; // drawer to bitmap
	logic [coordWidth-1:0] offsetX;
	logic [coordWidth-1:0] offsetY;
	color_t iconRgb; // bitmap to mux
	logic iconRequest;

	pixelScanner pixelScanner_i (
		.clk(clk),
		.resetN(resetN),
		.pix(pixBus.source)
	);

	gameControl gameControl_i (
		.clk(clk),
		.resetN(resetN),
		.eventValid(eventValid),
		.eventCode(eventCode),
		.lives(lives),
		.gameOver(gameOver)
	);

	lifeIconDrawer lifeIconDrawer_i (
		.clk(clk),
		.resetN(resetN),
		.pix(pixBus.sink),
		.lives(lives),
		.drawRequest(drawRequest),
		.offsetX(offsetX),
		.offsetY(offsetY)
	);

	iconBitmap iconBitmap_i (
		.clk(clk),
		.resetN(resetN),
		.drawRequest(drawRequest),
		.offsetX(offsetX),
		.offsetY(offsetY),
		.iconRgb(iconRgb),
		.iconRequest(iconRequest)
	);

	layerMux layerMux_i (
		.clk(clk),
		.resetN(resetN),
		.iconRgb(iconRgb),
		.iconRequest(iconRequest),
		.gameOver(gameOver),
		.rgb(rgb)
	);

	assign pixelX = pixBus.pixelX; // rgb for this position comes 3 cycles later
	assign pixelY = pixBus.pixelY;
	assign frameStart = pixBus.frameStart;

endmodule

`default_nettype wire

//--- bench/hudTop_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hudTop_assert (
	input logic clk,
	input logic resetN,
	input logic eventValid,
	input gamePkg::eventCode_t eventCode,
	input gamePkg::lives_t lives,
	input logic gameOver,
	input gamePkg::gameState_t state
);
	import gamePkg::*;

	int failCount = 0; // polled by the testbench at the end of the run

	// a full count only drops on a die, so a prize cannot wrap it past maxLives
	livesInRange: assert property (@(posedge clk) disable iff (!resetN)
		(lives == maxLives && !(eventValid && eventCode == evDie)) |=> (lives == maxLives))
		else begin
			$error("lives count moved past maxLives");
			failCount++;
		end

	overMeansNoLives: assert property (@(posedge clk) disable iff (!resetN)
		gameOver |-> (lives == '0))
		else begin
			$error("gameOver high with lives left");
			failCount++;
		end

	dieIgnoredInOver: assert property (@(posedge clk) disable iff (!resetN)
		(state == stOver && eventValid && eventCode == evDie) |=> $stable(lives))
		else begin
			$error("die event changed lives in stOver");
			failCount++;
		end

endmodule

bind gameControl hudTop_assert checks (
	.clk(clk),
	.resetN(resetN),
	.eventValid(eventValid),
	.eventCode(eventCode),
	.lives(lives),
	.gameOver(gameOver),
	.state(state)
);

`default_nettype wire

//--- bench/hudTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hudTop_tb;
	import videoPkg::*;
	import gamePkg::*;

	localparam int clkPeriod = 8; // ns
	localparam int framePixels = screenWidth * screenHeight;
	localparam int iconLeft [numIcons] = '{iconLeftX0, iconLeftX1, iconLeftX2};
	localparam longint watchdogTime = 12 * framePixels * clkPeriod; // all tests fit in 12 frames

	logic clk = 1'b0;
	logic resetN;
	logic eventValid;
	eventCode_t eventCode;
	logic [coordWidth-1:0] pixelX;
	logic [coordWidth-1:0] pixelY;
	logic frameStart;
	lives_t lives;
	logic gameOver;
	color_t rgb;

	lives_t expLives; // reference life count
	logic expOver; // reference game over flag
	logic [coordWidth-1:0] histX [3]; // position 1, 2 and 3 cycles back
	logic [coordWidth-1:0] histY [3];

	hudTop hudTop_i (
		.clk(clk),
		.resetN(resetN),
		.eventValid(eventValid),
		.eventCode(eventCode),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.frameStart(frameStart),
		.lives(lives),
		.gameOver(gameOver),
		.rgb(rgb)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// pre-edge position, so at a falling edge histX[2] is the pixel that rgb shows
	always @(posedge clk) begin
		histX[0] <= pixelX;
		histX[1] <= histX[0];
		histX[2] <= histX[1];
		histY[0] <= pixelY;
		histY[1] <= histY[0];
		histY[2] <= histY[1];
	end

	initial begin
		#(watchdogTime);
		$display("ERROR: watchdog timeout, tests still running after %0d ns", watchdogTime);
		$display("TEST FAILED");
		$fatal(1);
	end

	// icon k shows while k < icons, corners fall through to the background
	function automatic color_t expectedColor(input int x, input int y, input int icons,
			input logic over);
		int ox;
		int oy;
		for (int k = 0; k < icons; k++) begin
			ox = x - iconLeft[k];
			oy = y - iconTopY;
			if (ox >= 0 && ox < iconSize && oy >= 0 && oy < iconSize &&
					!((ox == 0 || ox == iconSize - 1) && (oy == 0 || oy == iconSize - 1))) begin
				return iconColor;
			end
		end
		return over ? gameOverColor : backgroundColor;
	endfunction

	task automatic compareColor(input color_t actual, input color_t expected, input int x,
			input int y);
		if (actual !== expected) begin
			$display("FAIL %0t: rgb for pixel (%0d,%0d) is %h, expected %h",
				$time, x, y, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic compareLives(input lives_t actual, input logic actualOver,
			input lives_t expected, input logic expectedOver, input string what);
		if (actual !== expected || actualOver !== expectedOver) begin
			$display("FAIL %0t: %s gives lives %0d gameOver %b, expected lives %0d gameOver %b",
				$time, what, actual, actualOver, expected, expectedOver);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// raster index counts pixels from (0,0) in row order
	task automatic comparePosition(input logic [coordWidth-1:0] actualX,
			input logic [coordWidth-1:0] actualY, input logic actualStart, input int index);
		logic [coordWidth-1:0] expX;
		logic [coordWidth-1:0] expY;
		logic expStart;
		expX = coordWidth'(index % screenWidth);
		expY = coordWidth'(index / screenWidth);
		expStart = (index == 0); // only the first pixel of a frame
		if (actualX !== expX || actualY !== expY || actualStart !== expStart) begin
			$display("FAIL %0t: scanner at (%0d,%0d) start %b, expected (%0d,%0d) start %b",
				$time, actualX, actualY, actualStart, expX, expY, expStart);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkPixel(input int icons, input logic over);
		@(negedge clk); // outputs settled mid-cycle
		compareColor(rgb, expectedColor(histX[2], histY[2], icons, over), histX[2], histY[2]);
	endtask

	task automatic checkFrame(input int icons, input logic over);
		do @(negedge clk); while (!frameStart);
		repeat (2) @(negedge clk); // pipeline still shows the old frame
		for (int i = 0; i < framePixels; i++) begin
			checkPixel(icons, over);
			comparePosition(pixelX, pixelY, frameStart, (i + 3) % framePixels); // 3 pixels ahead
		end
	endtask

	// rest of the frame in flight, including the 3 cycles after frameStart
	task automatic checkToFrameEnd(input int icons, input logic over);
		bit seen;
		seen = 1'b0;
		while (!seen) begin
			checkPixel(icons, over);
			seen = frameStart;
		end
		repeat (2) checkPixel(icons, over);
	endtask

	// reference rules for the event opcodes
	task automatic applyEvent(input eventCode_t code);
		if (code == evRestart) begin
			expLives = maxLives;
			expOver = 1'b0;
		end else if (!expOver && code == evDie) begin
			expLives = expLives - lives_t'(1);
			expOver = (expLives == '0); // last life gone
		end else if (!expOver && code == evPrize && expLives != maxLives) begin
			expLives = expLives + lives_t'(1);
		end
	endtask

	task automatic sendEvent(input eventCode_t code, input string what);
		@(posedge clk);
		#1;
		eventValid = 1'b1;
		eventCode = code;
		@(posedge clk); // event sampled here
		#1;
		eventValid = 1'b0;
		eventCode = evNone;
		applyEvent(code);
		compareLives(lives, gameOver, expLives, expOver, what);
	endtask

	task automatic testReset();
		compareLives(lives, gameOver, expLives, expOver, "reset");
		checkFrame(3, 1'b0);
	endtask

	task automatic testDieMidFrame();
		int x;
		int y;
		x = $urandom_range(screenWidth - 1);
		y = $urandom_range(iconTopY + iconSize - 2, iconTopY); // rest of frame still crosses icon 2
		do @(negedge clk); while (int'(pixelX) != x || int'(pixelY) != y);
		sendEvent(evDie, "die mid-frame");
		checkToFrameEnd(3, 1'b0); // snapshot still holds 3
		repeat (framePixels) checkPixel(2, 1'b0); // next frame, icon 2 gone
	endtask

	task automatic testPrize();
		sendEvent(evPrize, "prize at 2 lives");
		sendEvent(evPrize, "prize at 3 lives");
	endtask

	task automatic testGameOver();
		repeat (3) sendEvent(evDie, "die");
		sendEvent(evDie, "die in game over");
		sendEvent(evPrize, "prize in game over");
		checkFrame(0, 1'b1);
	endtask

	task automatic testRestart();
		sendEvent(evRestart, "restart from game over");
		checkFrame(3, 1'b0);
	endtask

	initial begin
		void'($urandom(16));
		resetN = 1'b0;
		eventValid = 1'b0;
		eventCode = evNone;
		expLives = maxLives;
		expOver = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		resetN = 1'b1;
		testReset();
		testDieMidFrame();
		testPrize();
		testGameOver();
		testRestart();
		if (hudTop_i.gameControl_i.checks.failCount != 0) begin
			$display("ERROR: %0d assertion failures in gameControl",
				hudTop_i.gameControl_i.checks.failCount);
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/videoPkg.sv
hdl/gamePkg.sv
hdl/pixelIf.sv
hdl/pixelScanner.sv
hdl/gameControl.sv
hdl/lifeIconDrawer.sv
hdl/iconBitmap.sv
hdl/layerMux.sv
hdl/hudTop.sv
bench/hudTop_assert.sv
bench/hudTop_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP = hudTop_tb
FLIST = flist.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
